/* hw/dacPkg.sv */
/* Shared widths, pair type and code conversion for the DAC output path.
   SampleBits must be at least 2 and FifoAddrBits at least 2 */
package dacPkg;

  // Width of one converter sample
  localparam int SampleBits = 10;

  // FIFO depth is 2**FifoAddrBits entries
  localparam int FifoAddrBits = 4;

  // One converter-coded sample
  typedef logic [SampleBits-1:0] sampleT;

  // Q in the upper half, I in the lower half
  typedef struct packed {
    sampleT q;
    sampleT i;
  } iqPairT;

  // Two's complement to converter code
  // MSB kept, all lower bits inverted
  function automatic sampleT toDacCode(input sampleT sample);
    return {sample[SampleBits-1], ~sample[SampleBits-2:0]};
  endfunction

endpackage

/* hw/dacSampleIn.sv */
`timescale 1ns/1ns
/* DSP-side input register. DspValid is a plain strobe with no back-pressure,
   so a registered sample that meets a full FIFO is lost and flagged on Dropped */
module dacSampleIn (
  input  logic           DspClk,
  input  logic           Reset,
  input  logic           DspValid,
  input  dacPkg::sampleT DspDataI,
  input  dacPkg::sampleT DspDataQ,
  input  logic           Full,
  output dacPkg::iqPairT WrData,
  output logic           WrEn,
  output logic           Dropped
);

  // Valid strobe delayed to line up with the payload
  logic validReg;

  // Recoded I/Q pair waiting for the FIFO
  dacPkg::iqPairT pairReg;

  always_ff @(posedge DspClk or posedge Reset) begin
    if (Reset) begin
      validReg <= 1'b0;
    end else begin
      validReg <= DspValid;
    end
  end

  // Payload only, converted on the way in
  always_ff @(posedge DspClk) begin
    pairReg.i <= dacPkg::toDacCode(DspDataI);
    pairReg.q <= dacPkg::toDacCode(DspDataQ);
  end

  assign WrData = pairReg;

  // Either a write or a drop for each registered sample
  assign WrEn    = validReg && !Full;
  assign Dropped = validReg && Full;

endmodule

/* hw/cdcFifo.sv */
`timescale 1ns/1ns
/* Dual-clock FIFO with Gray pointers. RdData is registered and valid one RdClk
   after an accepted read; writes when full and reads when empty are ignored */
module cdcFifo #(
  parameter int AddrBits = dacPkg::FifoAddrBits
) (
  input  logic           WrClk,
  input  logic           RdClk,
  input  logic           Reset,
  input  logic           WrEn,
  input  dacPkg::iqPairT WrData,
  input  logic           RdEn,
  output dacPkg::iqPairT RdData,
  output logic           Full,
  output logic           Empty
);

  localparam int Depth = 1 << AddrBits;

  // Storage
  dacPkg::iqPairT mem [Depth];

  // Per-domain reset release
  logic [1:0] wrRstSync;
  logic [1:0] rdRstSync;
  logic       wrRst;
  logic       rdRst;

  // Write side pointers, one extra bit for wrap
  logic [AddrBits:0] wrBin;
  logic [AddrBits:0] wrGray;
  logic [AddrBits:0] wrBinNext;
  logic [AddrBits:0] wrGrayNext;
  logic              wrAccept;

  // Read side pointers
  logic [AddrBits:0] rdBin;
  logic [AddrBits:0] rdGray;
  logic [AddrBits:0] rdBinNext;
  logic [AddrBits:0] rdGrayNext;
  logic              rdAccept;

  // Gray pointers brought into the opposite domain
  logic [AddrBits:0] rdGraySync1;
  logic [AddrBits:0] rdGraySync2;
  logic [AddrBits:0] wrGraySync1;
  logic [AddrBits:0] wrGraySync2;

  // Assert at once, release on the second local edge
  always_ff @(posedge WrClk or posedge Reset) begin
    if (Reset) begin
      wrRstSync <= 2'b11;
    end else begin
      wrRstSync <= {wrRstSync[0], 1'b0};
    end
  end

  always_ff @(posedge RdClk or posedge Reset) begin
    if (Reset) begin
      rdRstSync <= 2'b11;
    end else begin
      rdRstSync <= {rdRstSync[0], 1'b0};
    end
  end

  assign wrRst = wrRstSync[1];
  assign rdRst = rdRstSync[1];

  // Write domain
  assign wrAccept   = WrEn && !Full && !wrRst;
  assign wrBinNext  = wrBin + 1'b1;
  assign wrGrayNext = wrBinNext ^ (wrBinNext >> 1);

  always_ff @(posedge WrClk or posedge wrRst) begin
    if (wrRst) begin
      wrBin       <= '0;
      wrGray      <= '0;
      rdGraySync1 <= '0;
      rdGraySync2 <= '0;
    end else begin
      rdGraySync1 <= rdGray;
      rdGraySync2 <= rdGraySync1;
      if (wrAccept) begin
        wrBin  <= wrBinNext;
        wrGray <= wrGrayNext;
      end
    end
  end

  always_ff @(posedge WrClk) begin
    if (wrAccept) begin
      mem[wrBin[AddrBits-1:0]] <= WrData;
    end
  end

  // Full when the two top Gray bits differ and the rest match
  assign Full = (wrGray == {~rdGraySync2[AddrBits -: 2], rdGraySync2[AddrBits-2:0]});

  // Read domain
  assign rdAccept   = RdEn && !Empty && !rdRst;
  assign rdBinNext  = rdBin + 1'b1;
  assign rdGrayNext = rdBinNext ^ (rdBinNext >> 1);

  always_ff @(posedge RdClk or posedge rdRst) begin
    if (rdRst) begin
      rdBin       <= '0;
      rdGray      <= '0;
      wrGraySync1 <= '0;
      wrGraySync2 <= '0;
    end else begin
      wrGraySync1 <= wrGray;
      wrGraySync2 <= wrGraySync1;
      if (rdAccept) begin
        rdBin  <= rdBinNext;
        rdGray <= rdGrayNext;
      end
    end
  end

  // Registered read port
  always_ff @(posedge RdClk) begin
    if (rdAccept) begin
      RdData <= mem[rdBin[AddrBits-1:0]];
    end
  end

  assign Empty = (rdGray == wrGraySync2);

endmodule

/* hw/dacIqOutput.sv */
`timescale 1ns/1ns
/* Converter-side read control and behavioural dual-edge outputs. I is driven in
   the high half of ADC_CLK_IN and Q in the low half; the last pair repeats when empty */
module dacIqOutput (
  input  logic           ADC_CLK_IN,
  input  logic           Reset,
  input  logic           Empty,
  input  dacPkg::iqPairT RdData,
  output logic           RdEn,
  output dacPkg::sampleT DacData,
  output logic           DacIqSel,
  output logic           DacIqWrt,
  output logic           DacIqClk,
  output logic           DacIqReset
);

  // Local reset release
  logic [1:0] rstSync;
  logic       rstLocal;

  // Read accepted by the FIFO last cycle
  logic readDone;

  // Pair on the bus, I half used after the rising edge
  dacPkg::iqPairT outReg;

  // Q half moved onto the falling edge
  dacPkg::sampleT qLow;

  // Clock forwarding enable, changes only in the low phase
  logic fwdEn;
  logic fwdClk;

  always_ff @(posedge ADC_CLK_IN or posedge Reset) begin
    if (Reset) begin
      rstSync <= 2'b11;
    end else begin
      rstSync <= {rstSync[0], 1'b0};
    end
  end

  assign rstLocal = rstSync[1];

  // Read whenever not empty, load one cycle after the read
  always_ff @(posedge ADC_CLK_IN or posedge rstLocal) begin
    if (rstLocal) begin
      RdEn     <= 1'b0;
      readDone <= 1'b0;
      outReg   <= '0;
    end else begin
      RdEn     <= !Empty;
      // Same condition the FIFO uses to accept a read
      readDone <= RdEn && !Empty;
      if (readDone) begin
        outReg <= RdData;
      end
    end
  end

  // Falling-edge half of the output pair
  always_ff @(negedge ADC_CLK_IN or posedge rstLocal) begin
    if (rstLocal) begin
      qLow  <= '0;
      fwdEn <= 1'b0;
    end else begin
      qLow  <= outReg.q;
      fwdEn <= 1'b1;
    end
  end

  // Dual-edge mux standing in for the DDR cells
  assign DacData = ADC_CLK_IN ? outReg.i : qLow;

  // Select high marks the Q half
  assign DacIqSel = fwdEn && !ADC_CLK_IN;

  // Write and converter clocks share one gated copy
  assign fwdClk    = fwdEn && ADC_CLK_IN;
  assign DacIqWrt  = fwdClk;
  assign DacIqClk  = fwdClk;

  assign DacIqReset = rstLocal;

endmodule

/* hw/redPitayaDac.sv */
`timescale 1ns/1ns
/* Dual-channel DAC path from the DSP clock to ADC_CLK_IN. Reset is asynchronous
   and shared; samples arriving while the FIFO is full are dropped */
module redPitayaDac (
  input  logic           ADC_CLK_IN,
  input  logic           DspClk,
  input  logic           Reset,
  input  logic           DspValid,
  input  dacPkg::sampleT DspDataI,
  input  dacPkg::sampleT DspDataQ,
  output dacPkg::sampleT DacData,
  output logic           DacIqSel,
  output logic           DacIqWrt,
  output logic           DacIqClk,
  output logic           DacIqReset,
  output logic           Dropped
);

  // DSP side of the FIFO
  dacPkg::iqPairT wrData;
  logic           wrEn;
  logic           full;

  // Converter side of the FIFO
  dacPkg::iqPairT rdData;
  logic           rdEn;
  logic           empty;

  dacSampleIn i_dacSampleIn (
    .DspClk   (DspClk),
    .Reset    (Reset),
    .DspValid (DspValid),
    .DspDataI (DspDataI),
    .DspDataQ (DspDataQ),
    .Full     (full),
    .WrData   (wrData),
    .WrEn     (wrEn),
    .Dropped  (Dropped)
  );

  cdcFifo #(
    .AddrBits (dacPkg::FifoAddrBits)
  ) i_cdcFifo (
    .WrClk  (DspClk),
    .RdClk  (ADC_CLK_IN),
    .Reset  (Reset),
    .WrEn   (wrEn),
    .WrData (wrData),
    .RdEn   (rdEn),
    .RdData (rdData),
    .Full   (full),
    .Empty  (empty)
  );

  dacIqOutput i_dacIqOutput (
    .ADC_CLK_IN (ADC_CLK_IN),
    .Reset      (Reset),
    .Empty      (empty),
    .RdData     (rdData),
    .RdEn       (rdEn),
    .DacData    (DacData),
    .DacIqSel   (DacIqSel),
    .DacIqWrt   (DacIqWrt),
    .DacIqClk   (DacIqClk),
    .DacIqReset (DacIqReset)
  );

endmodule

/* dv/dacClkGen.sv */
`timescale 1ns/1ns
/* Bench clocks and reset. ADC_CLK_IN has a 10 ns period and DspClk 14 ns, or 6 ns
   while FastDsp is high. Reset is held for 10 ADC_CLK_IN cycles */
module dacClkGen (
  input  logic FastDsp,
  output logic ADC_CLK_IN,
  output logic DspClk,
  output logic Reset
);

  localparam int AdcHalf     = 5;
  localparam int DspSlowHalf = 7;
  localparam int DspFastHalf = 3;
  localparam int ResetCycles = 10;

  initial begin
    ADC_CLK_IN = 1'b0;
    forever #AdcHalf ADC_CLK_IN = ~ADC_CLK_IN;
  end

  // Half period chosen per phase, so a rate change lands within one phase
  initial begin
    DspClk = 1'b0;
    forever begin
      if (FastDsp) begin
        #DspFastHalf;
      end else begin
        #DspSlowHalf;
      end
      DspClk = ~DspClk;
    end
  end

  initial begin
    Reset <= 1'b1;
    repeat (ResetCycles) @(posedge ADC_CLK_IN);
    Reset <= 1'b0;
  end

endmodule

/* dv/dacMonitor.sv */
`timescale 1ns/1ns
/* Watches the DUT pins. Expected codes arrive from the bench with each strobe.
   DacData is sampled 1 ns before each ADC_CLK_IN edge and repeated pairs collapse */
module dacMonitor (
  input  logic           ADC_CLK_IN,
  input  logic           DspClk,
  input  logic           Reset,
  input  logic           DspValid,
  input  dacPkg::iqPairT ExpPair,
  input  dacPkg::sampleT DacData,
  input  logic           DacIqSel,
  input  logic           DacIqWrt,
  input  logic           DacIqClk,
  input  logic           DacIqReset,
  input  logic           Dropped,
  output int             ErrorCount,
  output int             PairCount,
  output int             DropCount
);

  localparam int SampleDelay = 4;

  // Pairs accepted by the FIFO, oldest first
  dacPkg::iqPairT expQueue [$];
  dacPkg::iqPairT pendPair = '0;
  dacPkg::iqPairT lastPair = '0;
  dacPkg::iqPairT nextPair;
  dacPkg::sampleT obsI;
  logic           pendValid = 1'b0;
  // Converter-side reset release, two ADC_CLK_IN edges after Reset falls
  logic [1:0]     rstShift = 2'b11;
  logic           inReset;
  // Forwarded clocks run from the high phase after the first low phase out of reset
  logic           clkLive = 1'b0;
  int             dspErrors = 0;
  int             outErrors = 0;
  int             pairSeen = 0;
  int             dropSeen = 0;

  assign ErrorCount = dspErrors + outErrors;
  assign PairCount  = pairSeen;
  assign DropCount  = dropSeen;

  // Mid-cycle, Dropped belongs to the strobe captured one DspClk earlier
  always @(negedge DspClk) begin
    if (pendValid) begin
      if (Dropped) begin
        dropSeen++;
      end else begin
        expQueue.push_back(pendPair);
      end
    end else if (Dropped) begin
      dspErrors++;
      $display("Dropped pulsed at %0t with no sample registered", $time);
    end
    pendValid = DspValid && !Reset;
    pendPair  = ExpPair;
  end

  // I near the end of the high phase, Q near the end of the low phase
  always @(posedge ADC_CLK_IN) begin
    rstShift = {rstShift[0], Reset};
    #SampleDelay;
    inReset = Reset || rstShift[1];
    obsI = DacData;
    if (DacIqSel !== 1'b0) begin
      outErrors++;
      $display("[ERROR] %0t DacIqSel expected 0 observed %b", $time, DacIqSel);
    end
    if (DacIqReset !== inReset) begin
      outErrors++;
      $display("[ERROR] %0t DacIqReset expected %b observed %b", $time, inReset, DacIqReset);
    end
    if (DacIqWrt !== clkLive) begin
      outErrors++;
      $display("[ERROR] %0t DacIqWrt expected %b observed %b", $time, clkLive, DacIqWrt);
    end
    if (DacIqClk !== clkLive) begin
      outErrors++;
      $display("[ERROR] %0t DacIqClk expected %b observed %b", $time, clkLive, DacIqClk);
    end
    @(negedge ADC_CLK_IN);
    #SampleDelay;
    if (DacIqSel !== !inReset) begin
      outErrors++;
      $display("[ERROR] %0t DacIqSel expected %b observed %b", $time, !inReset, DacIqSel);
    end
    if (DacIqWrt !== 1'b0) begin
      outErrors++;
      $display("[ERROR] %0t DacIqWrt expected 0 observed %b", $time, DacIqWrt);
    end
    if (DacIqClk !== 1'b0) begin
      outErrors++;
      $display("[ERROR] %0t DacIqClk expected 0 observed %b", $time, DacIqClk);
    end
    clkLive = !inReset;
    if (obsI !== lastPair.i || DacData !== lastPair.q) begin
      pairSeen++;
      if (expQueue.size() == 0) begin
        outErrors++;
        $display("Pair I=%h Q=%h appeared at %0t with no sample written", obsI, DacData, $time);
      end else begin
        nextPair = expQueue.pop_front();
        if (obsI !== nextPair.i) begin
          outErrors++;
          $display("[ERROR] %0t DacData(I) expected %h observed %h", $time, nextPair.i, obsI);
        end
        if (DacData !== nextPair.q) begin
          outErrors++;
          $display("[ERROR] %0t DacData(Q) expected %h observed %h", $time, nextPair.q, DacData);
        end
      end
      lastPair.i = obsI;
      lastPair.q = DacData;
    end
  end

endmodule

/* dv/dacTb_chk.sv */
`timescale 1ns/1ns
/* Assertions bound into redPitayaDac. The write pointer is reached through the
   i_cdcFifo instance, so both names must stay as they are */
module dacTb_chk #(
  parameter int PtrBits = dacPkg::FifoAddrBits + 1
) (
  input logic               ADC_CLK_IN,
  input logic               DspClk,
  input logic               Reset,
  input logic               Full,
  input logic [PtrBits-1:0] WrPtr,
  input logic               Empty,
  input logic               RdEn,
  input logic               DacIqSel,
  input logic               DacIqReset
);

  int wrFails = 0;
  int rdFails = 0;
  int FailCount;

  assign FailCount = wrFails + rdFails;

  // No write slips past a full FIFO
  assert property (@(posedge DspClk) disable iff (Reset) Full |=> $stable(WrPtr))
    else begin
      wrFails++;
      $error("FIFO write pointer advanced while Full was high");
    end

  // Read enable is registered from not empty
  assert property (@(posedge ADC_CLK_IN) disable iff (Reset) $past(Empty) |-> !RdEn)
    else begin
      rdFails++;
      $error("RdEn high after a cycle with Empty high");
    end

  // Just before a rising edge the clock is low, so the Q select must be high
  assert property (@(posedge ADC_CLK_IN) disable iff (Reset) !DacIqReset |-> DacIqSel)
    else begin
      rdFails++;
      $error("DacIqSel low during the low clock phase out of reset");
    end

endmodule

bind redPitayaDac dacTb_chk i_chk (
  .ADC_CLK_IN (ADC_CLK_IN),
  .DspClk     (DspClk),
  .Reset      (Reset),
  .Full       (full),
  .WrPtr      (i_cdcFifo.wrBin),
  .Empty      (empty),
  .RdEn       (rdEn),
  .DacIqSel   (DacIqSel),
  .DacIqReset (DacIqReset)
);

/* dv/dacTb.sv */
`timescale 1ns/1ns
/* DAC path testbench with sparse, continuous and burst sections. DspClk runs at
   6 ns in the burst so the FIFO overflows; assertion failures come from the i_chk bind */
module dacTb;

  localparam int SparseLen  = 32;
  localparam int ContLen    = 40;
  localparam int BurstLen   = 80;
  localparam int BurstStart = SparseLen + ContLen;
  localparam int TableLen   = BurstStart + BurstLen;
  localparam int IdleCycles = 20;
  // Three slow DspClk periods per entry plus drain, counted in ADC_CLK_IN cycles
  localparam int CycleLimit = TableLen * 3 * 14 / 10 + 200;

  logic           ADC_CLK_IN;
  logic           DspClk;
  logic           Reset;
  logic           fastDsp;
  logic           dspValid;
  dacPkg::sampleT dspDataI;
  dacPkg::sampleT dspDataQ;
  dacPkg::iqPairT expPair;
  dacPkg::sampleT dacData;
  logic           dacIqSel;
  logic           dacIqWrt;
  logic           dacIqClk;
  logic           dacIqReset;
  logic           dropped;
  int             monErrors;
  int             pairCount;
  int             dropCount;
  int             assertFails;
  int             benchErrors = 0;
  int             validCount = 0;
  int             cycleCount = 0;
  integer         seed = 95478;

  // Stimulus and expected converter codes, one entry per DspClk cycle
  logic           validTab [TableLen];
  dacPkg::sampleT iTab [TableLen];
  dacPkg::sampleT qTab [TableLen];
  dacPkg::iqPairT expTab [TableLen];

  // Sign bit kept, magnitude bits flipped
  function automatic dacPkg::sampleT expectedCode(input dacPkg::sampleT raw);
    return raw ^ {1'b0, {(dacPkg::SampleBits-1){1'b1}}};
  endfunction

  task automatic fillTable();
    dacPkg::sampleT cornerI [4];
    dacPkg::sampleT cornerQ [4];
    logic [31:0]    r;
    int             corner;
    dacPkg::sampleT lastI;
    dacPkg::sampleT lastQ;
    // Most negative, zero, all ones, most positive, Q reversed so no pair repeats
    cornerI[0] = {1'b1, {(dacPkg::SampleBits-1){1'b0}}};
    cornerI[1] = '0;
    cornerI[2] = '1;
    cornerI[3] = {1'b0, {(dacPkg::SampleBits-1){1'b1}}};
    for (int k = 0; k < 4; k++) begin
      cornerQ[k] = cornerI[3-k];
    end
    corner = 0;
    lastI  = '0;
    lastQ  = '0;
    for (int n = 0; n < TableLen; n++) begin
      validTab[n] = (n >= SparseLen) || (n % 4 == 0);
      if (validTab[n] && corner < 4) begin
        iTab[n] = cornerI[corner];
        qTab[n] = cornerQ[corner];
        corner++;
      end else begin
        // Reroll until the pair differs from the last valid one
        do begin
          r       = $random(seed);
          iTab[n] = r[dacPkg::SampleBits-1:0];
          qTab[n] = r[2*dacPkg::SampleBits-1:dacPkg::SampleBits];
        end while (iTab[n] == lastI && qTab[n] == lastQ);
      end
      if (validTab[n]) begin
        lastI = iTab[n];
        lastQ = qTab[n];
      end
      expTab[n].i = expectedCode(iTab[n]);
      expTab[n].q = expectedCode(qTab[n]);
    end
  endtask

  dacClkGen i_dacClkGen (
    .FastDsp    (fastDsp),
    .ADC_CLK_IN (ADC_CLK_IN),
    .DspClk     (DspClk),
    .Reset      (Reset)
  );

  redPitayaDac i_redPitayaDac (
    .ADC_CLK_IN (ADC_CLK_IN),
    .DspClk     (DspClk),
    .Reset      (Reset),
    .DspValid   (dspValid),
    .DspDataI   (dspDataI),
    .DspDataQ   (dspDataQ),
    .DacData    (dacData),
    .DacIqSel   (dacIqSel),
    .DacIqWrt   (dacIqWrt),
    .DacIqClk   (dacIqClk),
    .DacIqReset (dacIqReset),
    .Dropped    (dropped)
  );

  dacMonitor i_dacMonitor (
    .ADC_CLK_IN (ADC_CLK_IN),
    .DspClk     (DspClk),
    .Reset      (Reset),
    .DspValid   (dspValid),
    .ExpPair    (expPair),
    .DacData    (dacData),
    .DacIqSel   (dacIqSel),
    .DacIqWrt   (dacIqWrt),
    .DacIqClk   (dacIqClk),
    .DacIqReset (dacIqReset),
    .Dropped    (dropped),
    .ErrorCount (monErrors),
    .PairCount  (pairCount),
    .DropCount  (dropCount)
  );

  initial begin
    fastDsp  <= 1'b0;
    dspValid <= 1'b0;
    dspDataI <= '0;
    dspDataQ <= '0;
    expPair  <= '0;
    fillTable();
    @(negedge Reset);
    // Both synchronized resets released
    repeat (8) @(posedge ADC_CLK_IN);
    for (int n = 0; n < TableLen; n++) begin
      @(posedge DspClk);
      if (n == BurstStart) begin
        if (dropCount != 0) begin
          benchErrors++;
          $display("Samples were dropped before the burst section");
        end
        fastDsp <= 1'b1;
      end
      dspValid <= validTab[n];
      dspDataI <= iTab[n];
      dspDataQ <= qTab[n];
      expPair  <= expTab[n];
      if (validTab[n]) begin
        validCount++;
      end
    end
    @(posedge DspClk);
    dspValid <= 1'b0;
    fastDsp  <= 1'b0;
    // Every valid entry either leaves the bus or is dropped
    while (pairCount + dropCount < validCount) begin
      @(posedge ADC_CLK_IN);
    end
    // Extra idle time catches invented pairs
    repeat (IdleCycles) @(posedge ADC_CLK_IN);
    if (dropCount == 0) begin
      benchErrors++;
      $display("The burst section did not overflow the FIFO");
    end
    if (pairCount + dropCount != validCount) begin
      benchErrors++;
      $display("%0d pairs and %0d drops for %0d valid samples", pairCount, dropCount, validCount);
    end
    assertFails = i_redPitayaDac.i_chk.FailCount;
    $display("Errors: monitor %0d, assertions %0d, bench %0d", monErrors, assertFails,
             benchErrors);
    if (monErrors + assertFails + benchErrors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Run limit
  always @(posedge ADC_CLK_IN) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout after %0d ADC_CLK_IN cycles, output did not drain", cycleCount);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

/* src.f */
hw/dacPkg.sv
hw/dacSampleIn.sv
hw/cdcFifo.sv
hw/dacIqOutput.sv
hw/redPitayaDac.sv
dv/dacClkGen.sv
dv/dacMonitor.sv
dv/dacTb_chk.sv
dv/dacTb.sv

/* Makefile */
# Verilator build and run for the DAC output path
VERILATOR ?= verilator
TOP       ?= dacTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST PASSED
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
